//--- design/lc4_cfg.svh
// ----------------------------------------------------------------------
// global sizes of the lc4 pipeline core
// word width, register file size and the pc after reset
// ----------------------------------------------------------------------
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// data and address width
`define LC4_WORD_W 16

// eight general purpose registers r0..r7
`define LC4_NREGS 8
`define LC4_RSEL_W 3

// first fetch address, start of user code
`define LC4_RESET_PC 16'h8200

`endif

//--- design/lc4_isa_pkg.sv
// ----------------------------------------------------------------------
// instruction level types of the lc4 subset
// word, register select, nzp, opcodes, decoded control, nzp helper
// ----------------------------------------------------------------------
`include "lc4_cfg.svh"

package lc4_isa_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [`LC4_RSEL_W-1:0] reg_sel_t;

    // one-hot {n, z, p}
    typedef logic [2:0] nzp_t;

    // only the kept opcodes, everything else decodes as nothing
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_t;

    // decoded control travelling with each instruction
    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } ctrl_t;

    // condition code of a written value, taken as signed
    function automatic nzp_t nzp_of(word_t v);
        if ($signed(v) > 0) return 3'b001;
        if (v == '0) return 3'b010;
        return 3'b100;
    endfunction

endpackage

//--- design/lc4_pipe_pkg.sv
// ----------------------------------------------------------------------
// pipeline level types, stall kinds, stage latch and writeback trace
// ----------------------------------------------------------------------
package lc4_pipe_pkg;
    import lc4_isa_pkg::*;

    // stall code 1 belongs to the second pipe and never occurs here
    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_kind_t;

    // latch between two stages
    typedef struct packed {
        word_t       pc;
        word_t       insn;
        ctrl_t       ctrl;
        word_t       imm;
        stall_kind_t stall;
    } stage_t;

    // what the retiring slot did, seen from writeback
    typedef struct packed {
        word_t       pc;
        word_t       insn;
        stall_kind_t stall;
        logic        rf_we;
        reg_sel_t    wsel;
        word_t       wdata;
        logic        nzp_we;
        nzp_t        nzp;
        logic        dmem_we;
        word_t       dmem_addr;
        word_t       dmem_data;
    } wb_trace_t;

    // empty slot, insn 0 is a nop and all enables are low
    function automatic stage_t make_bubble(stall_kind_t kind);
        stage_t s;
        s       = '0;
        s.stall = kind;
        return s;
    endfunction

endpackage

//--- design/lc4_decoder.sv
// ----------------------------------------------------------------------
// lc4 decoder, control struct and sign extended immediate
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lc4_decoder import lc4_isa_pkg::*; (
    input  word_t i_insn,
    output ctrl_t o_ctrl,
    output word_t o_imm
);

    opcode_t op;

    assign op = opcode_t'(i_insn[15:12]);

    always_comb begin
        o_ctrl = '0;
        o_imm  = '0;
        // common field positions, rt moves for stores
        o_ctrl.rs = i_insn[8:6];
        o_ctrl.rt = i_insn[2:0];
        o_ctrl.rd = i_insn[11:9];
        case (op)
            OP_BR: begin
                // condition bits stay in the insn, execute reads them
                o_ctrl.is_branch = 1'b1;
                o_imm            = word_t'($signed(i_insn[8:0]));
            end
            OP_ADD: begin
                o_ctrl.rs_re = 1'b1;
                o_ctrl.rd_we = 1'b1;
                // bit 5 picks the imm5 form
                if (i_insn[5]) begin
                    o_imm = word_t'($signed(i_insn[4:0]));
                end else begin
                    o_ctrl.rt_re = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.is_load = 1'b1;
                o_imm          = word_t'($signed(i_insn[5:0]));
            end
            OP_STR: begin
                // store data register sits where rd would be
                o_ctrl.rt       = i_insn[11:9];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_imm           = word_t'($signed(i_insn[5:0]));
            end
            OP_CONST: begin
                o_ctrl.rd_we = 1'b1;
                o_imm        = word_t'($signed(i_insn[8:0]));
            end
            default: begin
            end
        endcase
        // every register writer also sets the condition codes
        o_ctrl.nzp_we = o_ctrl.rd_we;
    end

endmodule

//--- design/lc4_regfile.sv
// ----------------------------------------------------------------------
// register file, two read ports, one write port, write-through
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "lc4_cfg.svh"

module lc4_regfile import lc4_isa_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst_n,
    input  reg_sel_t i_rs,
    input  reg_sel_t i_rt,
    output word_t    o_rs_data,
    output word_t    o_rt_data,
    input  reg_sel_t i_rd,
    input  word_t    i_wdata,
    input  logic     i_we
);

    word_t regs [`LC4_NREGS];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // writeback and decode in the same cycle, decode sees the new value
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

//--- design/lc4_execute.sv
// ----------------------------------------------------------------------
// execute stage, mx/wx bypass, adder, nzp pick, branch resolution
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lc4_execute import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  stage_t   i_x,
    input  word_t    i_rs_data,
    input  word_t    i_rt_data,
    input  reg_sel_t i_m_rd,
    input  logic     i_m_we,
    input  word_t    i_m_result,
    input  nzp_t     i_m_nzp,
    input  logic     i_m_nzp_we,
    input  reg_sel_t i_w_rd,
    input  logic     i_w_we,
    input  word_t    i_w_result,
    input  nzp_t     i_w_nzp,
    input  logic     i_w_nzp_we,
    input  nzp_t     i_nzp_reg,
    output word_t    o_result,
    output word_t    o_store_data,
    output logic     o_br_taken,
    output word_t    o_target
);

    word_t rs_val;
    word_t rt_val;
    word_t op_a;
    word_t op_b;
    nzp_t  nzp_sel;

    // memory stage first, then writeback, then the latched regfile read
    assign rs_val = (i_m_we && i_m_rd == i_x.ctrl.rs) ? i_m_result :
                    (i_w_we && i_w_rd == i_x.ctrl.rs) ? i_w_result :
                    i_rs_data;
    assign rt_val = (i_m_we && i_m_rd == i_x.ctrl.rt) ? i_m_result :
                    (i_w_we && i_w_rd == i_x.ctrl.rt) ? i_w_result :
                    i_rt_data;

    // const has no rs, so it adds imm to zero
    assign op_a = i_x.ctrl.rs_re ? rs_val : '0;
    // register add uses rt, imm add and address calc use imm
    assign op_b = (i_x.ctrl.rt_re && !i_x.ctrl.is_store) ? rt_val : i_x.imm;

    assign o_result     = op_a + op_b;
    assign o_store_data = rt_val;

    // youngest older writer of the condition codes wins
    assign nzp_sel = i_m_nzp_we ? i_m_nzp :
                     i_w_nzp_we ? i_w_nzp :
                     i_nzp_reg;

    // insn[11:9] holds the n, z, p test bits of a BR
    assign o_br_taken = i_x.ctrl.is_branch && |(nzp_sel & i_x.insn[11:9]);
    assign o_target   = i_x.pc + word_t'(1) + i_x.imm;

endmodule

//--- design/lc4_pc_counter.sv
// ----------------------------------------------------------------------
// program counter, increments, holds or takes a branch target
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "lc4_cfg.svh"

module lc4_pc_counter import lc4_isa_pkg::*; (
    input  logic  gwe,
    input  logic  i_rst_n,
    input  logic  i_hold,
    input  logic  i_load,
    input  word_t i_target,
    output word_t o_pc
);

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= `LC4_RESET_PC;
        end else if (i_load) begin
            // a taken branch overrides any load stall
            o_pc <= i_target;
        end else if (!i_hold) begin
            o_pc <= o_pc + word_t'(1);
        end
    end

endmodule

//--- design/lc4_hazard_ctrl.sv
// ----------------------------------------------------------------------
// hazard control, load-to-use stall and branch flush
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lc4_hazard_ctrl import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  ctrl_t       i_d_ctrl,
    input  ctrl_t       i_x_ctrl,
    input  logic        i_br_taken,
    output logic        o_stall_d,
    output logic        o_flush,
    output stall_kind_t o_bubble_kind
);

    logic rs_dep;
    logic rt_dep;

    // decode reads a register that the load in execute has not fetched yet
    assign rs_dep = i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd;
    assign rt_dep = i_d_ctrl.rt_re && i_d_ctrl.rt == i_x_ctrl.rd;

    // a branch waits for the nzp bits of the load too
    assign o_stall_d = i_x_ctrl.is_load && (rs_dep || rt_dep || i_d_ctrl.is_branch);
    assign o_flush   = i_br_taken;

    always_comb begin
        if (o_flush) begin
            o_bubble_kind = STALL_BRANCH;
        end else if (o_stall_d) begin
            o_bubble_kind = STALL_LOAD;
        end else begin
            o_bubble_kind = STALL_NONE;
        end
    end

endmodule

//--- design/lc4_core.sv
// ----------------------------------------------------------------------
// lc4 five stage core, stage latches, memory mux, wm bypass, trace
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lc4_core import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst_n,
    output word_t     o_cur_pc,
    input  word_t     i_cur_insn,
    output word_t     o_dmem_addr,
    output logic      o_dmem_we,
    output word_t     o_dmem_towrite,
    input  word_t     i_dmem_data,
    output wb_trace_t o_trace
);

    stage_t d_q, x_q, m_q, w_q;
    stage_t d_stage;
    ctrl_t d_ctrl;
    word_t d_imm, rs_data, rt_data;
    word_t x_rs_q, x_rt_q, x_result, x_store, br_target;
    word_t m_result_q, m_store_q, m_value, m_towrite;
    word_t w_value_q, w_addr_q, w_mdata_q;
    nzp_t m_nzp, w_nzp, nzp_q;
    logic br_taken, stall_d, flush;
    stall_kind_t bubble_kind;

    lc4_pc_counter u_pc (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_hold(stall_d), .i_load(br_taken),
        .i_target(br_target), .o_pc(o_cur_pc)
    );

    // decode works on the d latch, ctrl and imm are filled here
    lc4_decoder u_dec (.i_insn(d_q.insn), .o_ctrl(d_ctrl), .o_imm(d_imm));
    assign d_stage = '{pc: d_q.pc, insn: d_q.insn, ctrl: d_ctrl, imm: d_imm,
                       stall: d_q.stall};

    lc4_regfile u_rf (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_ctrl.rs), .i_rt(d_ctrl.rt),
        .o_rs_data(rs_data), .o_rt_data(rt_data),
        .i_rd(w_q.ctrl.rd), .i_wdata(w_value_q), .i_we(w_q.ctrl.rd_we)
    );

    lc4_hazard_ctrl u_hz (
        .i_d_ctrl(d_ctrl), .i_x_ctrl(x_q.ctrl), .i_br_taken(br_taken),
        .o_stall_d(stall_d), .o_flush(flush), .o_bubble_kind(bubble_kind)
    );

    lc4_execute u_ex (
        .i_x(x_q), .i_rs_data(x_rs_q), .i_rt_data(x_rt_q),
        .i_m_rd(m_q.ctrl.rd), .i_m_we(m_q.ctrl.rd_we), .i_m_result(m_value),
        .i_m_nzp(m_nzp), .i_m_nzp_we(m_q.ctrl.nzp_we),
        .i_w_rd(w_q.ctrl.rd), .i_w_we(w_q.ctrl.rd_we), .i_w_result(w_value_q),
        .i_w_nzp(w_nzp), .i_w_nzp_we(w_q.ctrl.nzp_we), .i_nzp_reg(nzp_q),
        .o_result(x_result), .o_store_data(x_store),
        .o_br_taken(br_taken), .o_target(br_target)
    );

    // memory stage, a load hands over the returned data
    assign m_value = m_q.ctrl.is_load ? i_dmem_data : m_result_q;
    assign m_nzp   = nzp_of(m_value);
    assign w_nzp   = nzp_of(w_value_q);
    // wm bypass when the store data comes from the slot in writeback
    assign m_towrite = (m_q.ctrl.is_store && w_q.ctrl.rd_we && w_q.ctrl.rd == m_q.ctrl.rt) ?
                       w_value_q : m_store_q;

    assign o_dmem_we      = m_q.ctrl.is_store;
    assign o_dmem_addr    = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_result_q : '0;
    assign o_dmem_towrite = m_towrite;

    // stage latches, reset fills the pipe with branch bubbles
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            d_q   <= make_bubble(STALL_BRANCH);
            x_q   <= make_bubble(STALL_BRANCH);
            m_q   <= make_bubble(STALL_BRANCH);
            w_q   <= make_bubble(STALL_BRANCH);
            nzp_q <= '0;
        end else begin
            // flush beats stall, stall holds fetch and decode
            if (flush) begin
                d_q <= make_bubble(bubble_kind);
            end else if (!stall_d) begin
                d_q <= '{pc: o_cur_pc, insn: i_cur_insn, ctrl: '0, imm: '0,
                         stall: STALL_NONE};
            end
            x_q <= (flush || stall_d) ? make_bubble(bubble_kind) : d_stage;
            m_q <= x_q;
            w_q <= m_q;
            if (w_q.ctrl.nzp_we) begin
                nzp_q <= w_nzp;
            end
        end
    end

    // payload registers
    always_ff @(posedge gwe) begin
        x_rs_q     <= rs_data;
        x_rt_q     <= rt_data;
        m_result_q <= x_result;
        m_store_q  <= x_store;
        w_value_q  <= m_value;
        w_addr_q   <= m_result_q;
        w_mdata_q  <= m_q.ctrl.is_store ? m_towrite : i_dmem_data;
    end

    // trace of the retiring slot, unused fields read as zero
    always_comb begin
        o_trace.pc        = w_q.pc;
        o_trace.insn      = w_q.insn;
        o_trace.stall     = w_q.stall;
        o_trace.rf_we     = w_q.ctrl.rd_we;
        o_trace.wsel      = w_q.ctrl.rd;
        o_trace.wdata     = w_q.ctrl.rd_we ? w_value_q : '0;
        o_trace.nzp_we    = w_q.ctrl.nzp_we;
        o_trace.nzp       = w_q.ctrl.nzp_we ? w_nzp : '0;
        o_trace.dmem_we   = w_q.ctrl.is_store;
        o_trace.dmem_addr = (w_q.ctrl.is_load || w_q.ctrl.is_store) ? w_addr_q : '0;
        o_trace.dmem_data = (w_q.ctrl.is_load || w_q.ctrl.is_store) ? w_mdata_q : '0;
    end

endmodule

//--- test/lc4_core_properties.sv
// ----------------------------------------------------------------------
// concurrent checks on the lc4 core ports, bound into the core
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lc4_core_properties import lc4_isa_pkg::*, lc4_pipe_pkg::*; (
    input logic      gwe,
    input logic      i_rst_n,
    input logic      i_dmem_we,
    input word_t     i_dmem_addr,
    input wb_trace_t i_trace
);

    // a data memory write belongs to a store that retires on the next edge
    a_we_only_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_dmem_we |=> (i_trace.dmem_we && i_trace.stall == STALL_NONE &&
                       i_trace.dmem_addr == $past(i_dmem_addr)))
        else $error("data memory write not followed by a retiring store at that address");

    // single pipe, so stall code 1 never shows up
    a_no_code_one: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_trace.stall != 2'd1)
        else $error("writeback trace shows stall code 1");

    // a bubble never writes the register file
    a_bubble_no_write: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_trace.stall != STALL_NONE) |-> !i_trace.rf_we)
        else $error("bubble in writeback with rf_we set");

endmodule

bind lc4_core lc4_core_properties u_props (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_dmem_we(o_dmem_we),
    .i_dmem_addr(o_dmem_addr), .i_trace(o_trace)
);

//--- test/lc4_core_tb.sv
// ----------------------------------------------------------------------
// lc4 core testbench, clock, reset, instruction and data memory models
// program table and expected writeback trace checked in a loop
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "lc4_cfg.svh"

module lc4_core_tb import lc4_isa_pkg::*, lc4_pipe_pkg::*; ();

    localparam int   N_ROWS = 18;
    localparam nzp_t NZP_N  = 3'b100;
    localparam nzp_t NZP_Z  = 3'b010;
    localparam nzp_t NZP_P  = 3'b001;

    // one expected retiring slot
    typedef struct packed {
        stall_kind_t stall;
        word_t       pc;
        logic        rf_we;
        reg_sel_t    wsel;
        word_t       wdata;
        nzp_t        nzp;
        logic        dmem_we;
        word_t       dmem_addr;
        word_t       dmem_data;
    } exp_row_t;

    logic      gwe;
    logic      i_rst_n;
    word_t     cur_pc;
    word_t     cur_insn;
    word_t     imem_off;
    word_t     dmem_addr;
    logic      dmem_we;
    word_t     dmem_towrite;
    word_t     dmem_rdata;
    wb_trace_t trace;

    word_t    prog [32];
    word_t    dmem [65536];
    exp_row_t exp_rows [N_ROWS];

    lc4_core dut (
        .gwe(gwe), .i_rst_n(i_rst_n), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
        .i_dmem_data(dmem_rdata), .o_trace(trace)
    );

    // 40 ns period
    always #20 gwe = ~gwe;

    // imem answers the pc in the same cycle, nop outside the program
    assign imem_off = cur_pc - `LC4_RESET_PC;
    assign cur_insn = (imem_off < 16'd32) ? prog[imem_off[4:0]] : 16'h0000;

    // dmem read is combinational, write lands on the rising edge
    assign dmem_rdata = dmem[dmem_addr];
    always @(posedge gwe) begin
        if (!i_rst_n) begin
            // fill depends on the full address
            for (int i = 0; i < 65536; i++) begin
                dmem[i] <= word_t'(i) ^ 16'hc3a5;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr] <= dmem_towrite;
        end
    end

    function automatic exp_row_t row_of(stall_kind_t s, word_t pc, logic we,
                                        reg_sel_t sel, word_t d, nzp_t n);
        exp_row_t r;
        r       = '0;
        r.stall = s;
        r.pc    = pc;
        r.rf_we = we;
        r.wsel  = sel;
        r.wdata = d;
        r.nzp   = n;
        return r;
    endfunction

    task automatic fill_program();
        for (int i = 0; i < 32; i++) begin
            prog[i] = 16'h0000;
        end
        // r1 = 5, r2 = r1 + r1, r3 = r2 + r1, r4 = r3 - 3
        prog[0]  = 16'h9205;
        prog[1]  = 16'h1441;
        prog[2]  = 16'h1681;
        prog[3]  = 16'h18fd;
        // r5 = 80, r6 = r4 + 7, mem[r5 + 2] = r6, r7 = mem[r5 + 2]
        prog[4]  = 16'h9a50;
        prog[5]  = 16'h1d27;
        prog[6]  = 16'h7d42;
        prog[7]  = 16'h6f42;
        // load-to-use, r1 = r7 + r6
        prog[8]  = 16'h13c6;
        // r2 = r3 - 15 is zero, brz +2 skips two consts
        prog[9]  = 16'h14f1;
        prog[10] = 16'h0402;
        prog[11] = 16'h9601;
        prog[12] = 16'h9602;
        // r4 = -7, r4 = r4 + 10, brn +5 falls through, r5 = r4 + r7
        prog[13] = 16'h99f9;
        prog[14] = 16'h192a;
        prog[15] = 16'h0805;
        prog[16] = 16'h1b07;
    endtask

    task automatic fill_expected();
        // back to back adds over mx and wx bypass
        exp_rows[0]  = row_of(STALL_NONE, 16'h8200, 1'b1, 3'd1, 16'h0005, NZP_P);
        exp_rows[1]  = row_of(STALL_NONE, 16'h8201, 1'b1, 3'd2, 16'h000a, NZP_P);
        exp_rows[2]  = row_of(STALL_NONE, 16'h8202, 1'b1, 3'd3, 16'h000f, NZP_P);
        exp_rows[3]  = row_of(STALL_NONE, 16'h8203, 1'b1, 3'd4, 16'h000c, NZP_P);
        exp_rows[4]  = row_of(STALL_NONE, 16'h8204, 1'b1, 3'd5, 16'h0050, NZP_P);
        exp_rows[5]  = row_of(STALL_NONE, 16'h8205, 1'b1, 3'd6, 16'h0013, NZP_P);
        // store 19 at 0x52 and read it back
        exp_rows[6]  = row_of(STALL_NONE, 16'h8206, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_rows[6].dmem_we   = 1'b1;
        exp_rows[6].dmem_addr = 16'h0052;
        exp_rows[6].dmem_data = 16'h0013;
        exp_rows[7]  = row_of(STALL_NONE, 16'h8207, 1'b1, 3'd7, 16'h0013, NZP_P);
        exp_rows[7].dmem_addr = 16'h0052;
        exp_rows[7].dmem_data = 16'h0013;
        // one load bubble, then 19 + 19
        exp_rows[8]  = row_of(STALL_LOAD, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_rows[9]  = row_of(STALL_NONE, 16'h8208, 1'b1, 3'd1, 16'h0026, NZP_P);
        // zero result, taken brz, two flushed slots
        exp_rows[10] = row_of(STALL_NONE, 16'h8209, 1'b1, 3'd2, 16'h0000, NZP_Z);
        exp_rows[11] = row_of(STALL_NONE, 16'h820a, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_rows[12] = row_of(STALL_BRANCH, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_rows[13] = row_of(STALL_BRANCH, 16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000);
        // branch target, then brn not taken and no bubbles
        exp_rows[14] = row_of(STALL_NONE, 16'h820d, 1'b1, 3'd4, 16'hfff9, NZP_N);
        exp_rows[15] = row_of(STALL_NONE, 16'h820e, 1'b1, 3'd4, 16'h0003, NZP_P);
        exp_rows[16] = row_of(STALL_NONE, 16'h820f, 1'b0, 3'd0, 16'h0000, 3'b000);
        exp_rows[17] = row_of(STALL_NONE, 16'h8210, 1'b1, 3'd5, 16'h0016, NZP_P);
    endtask

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_word(input string what, input word_t got, input word_t want);
        assert (got == want) else begin
            $display("[FAIL] %0d ns: %s is 0x%h, expected 0x%h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    // empty slot in writeback, code 2 and nothing written
    task automatic check_bubble_state(input string what);
        expect_word({what, " stall"}, word_t'(trace.stall), word_t'(STALL_BRANCH));
        expect_word({what, " rf_we"}, word_t'(trace.rf_we), 16'h0000);
        expect_word({what, " dmem_we"}, word_t'(dmem_we), 16'h0000);
    endtask

    task automatic check_reset_state();
        expect_word("reset pc", cur_pc, `LC4_RESET_PC);
        check_bubble_state("reset");
    endtask

    task automatic check_row(input int idx, input exp_row_t e);
        string where;
        word_t off;
        where = $sformatf("row %0d", idx);
        off   = e.pc - `LC4_RESET_PC;
        expect_word({where, " stall"}, word_t'(trace.stall), word_t'(e.stall));
        expect_word({where, " rf_we"}, word_t'(trace.rf_we), word_t'(e.rf_we));
        expect_word({where, " dmem_we"}, word_t'(trace.dmem_we), word_t'(e.dmem_we));
        // a bubble has no pc or payload
        if (e.stall == STALL_NONE) begin
            expect_word({where, " pc"}, trace.pc, e.pc);
            expect_word({where, " insn"}, trace.insn, prog[off[4:0]]);
            expect_word({where, " dmem_addr"}, trace.dmem_addr, e.dmem_addr);
            expect_word({where, " dmem_data"}, trace.dmem_data, e.dmem_data);
        end
        // register writers also carry the sign of wdata
        if (e.rf_we) begin
            expect_word({where, " wsel"}, word_t'(trace.wsel), word_t'(e.wsel));
            expect_word({where, " wdata"}, trace.wdata, e.wdata);
            expect_word({where, " nzp_we"}, word_t'(trace.nzp_we), 16'h0001);
            expect_word({where, " nzp"}, word_t'(trace.nzp), word_t'(e.nzp));
        end
    endtask

    initial begin
        int wait_cycles;
        gwe     = 1'b0;
        i_rst_n = 1'b0;
        fill_program();
        fill_expected();

        // reset for five cycles, inputs move on the falling edge
        repeat (5) begin
            @(negedge gwe);
            check_reset_state();
        end
        i_rst_n = 1'b1;
        check_reset_state();

        // bubbles drain until the first fetched instruction retires
        wait_cycles = 0;
        @(negedge gwe);
        while (trace.stall != STALL_NONE) begin
            check_bubble_state("bubble after reset");
            wait_cycles++;
            if (wait_cycles > 20) begin
                $display("timeout: no instruction retired within 20 cycles after reset");
                stop_with_failure();
            end
            @(negedge gwe);
        end
        // fourth edge after reset, so three bubbles before it
        expect_word("cycles before first retire", word_t'(wait_cycles), 16'd3);

        // one retiring slot per cycle
        for (int r = 0; r < N_ROWS; r++) begin
            check_row(r, exp_rows[r]);
            @(negedge gwe);
        end

        // stored word still in data memory
        expect_word("dmem[0x52]", dmem[16'h0052], 16'h0013);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+design
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_execute.sv
design/lc4_pc_counter.sv
design/lc4_hazard_ctrl.sv
design/lc4_core.sv
test/lc4_core_properties.sv
test/lc4_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the lc4 core testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lc4_core_tb -f filelist.f -o Vlc4_core_tb

if ! output=$(./obj_dir/Vlc4_core_tb 2>&1); then
    echo "$output"
    echo "simulation exited with an error"
    exit 1
fi
echo "$output"
echo "$output" | grep -q "TEST RESULT: PASS"
